/* rtl/traffic_pkg.sv */
package traffic_pkg;

    // phase timer, long enough for the 60 tick greens
    typedef logic [5:0] timer_t;

    // main road is north/south, cross road is east/west
    // names follow the road whose traffic is moving
    typedef enum logic [3:0] {
        main_green,
        main_amber,
        main_clear,     // all red after the main road
        left_turn,      // protected arrow, every road red
        cross_walk,
        cross_flash,
        cross_dont,
        cross_green,
        cross_amber,
        cross_clear,    // all red after the cross road
        main_walk,
        main_flash,
        main_dont
    } phase_t;

    // length of each phase in ticks
    function automatic timer_t phase_duration(phase_t p);
        timer_t d;
        case (p)
            main_green, cross_green: d = timer_t'(60);
            main_amber, cross_amber: d = timer_t'(6);
            main_clear, cross_clear: d = timer_t'(2);
            left_turn:               d = timer_t'(20);
            main_walk, cross_walk:   d = timer_t'(10);
            main_flash, cross_flash: d = timer_t'(20);
            main_dont, cross_dont:   d = timer_t'(30);
            default:                 d = timer_t'(60);
        endcase
        return d;
    endfunction

    // seven segment patterns, segment on when the bit is low
    localparam logic [6:0] seg_walk      = 7'b1011111; // walking figure
    localparam logic [6:0] seg_dont_walk = 7'b0100001; // raised hand
    localparam logic [6:0] seg_blank     = 7'b1111111; // all segments dark

endpackage

/* rtl/tick_gen.sv */
`timescale 1ns/1ps

module tick_gen #(
    parameter int tick_div_slow = 27000000, // clk cycles per tick, normal rate
    parameter int tick_div_fast = 2700000   // clk cycles per tick, overclock
) (
    input  logic clk,
    input  logic reset,
    input  logic overclock,
    output logic tick,
    output logic beat
);

    localparam int cnt_w = $clog2(tick_div_slow);

    logic [cnt_w-1:0] count;
    logic [cnt_w-1:0] limit;
    logic             wrap;

    // divisor picked live, a shorter limit just ends the current count early
    assign limit = overclock ? cnt_w'(tick_div_fast - 1) : cnt_w'(tick_div_slow - 1);
    assign wrap  = (count >= limit);

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            count <= '0;
            tick  <= 1'b0;
            beat  <= 1'b0;
        end
        else
        begin
            tick <= wrap;                       // one cycle pulse per wrap
            if (wrap)
            begin
                count <= '0;
                beat  <= ~beat;                 // flash beat flips with each tick
            end
            else
                count <= count + 1'b1;
        end
    end

endmodule

/* rtl/phase_sequencer.sv */
`timescale 1ns/1ps

module phase_sequencer (
    input  logic                clk,
    input  logic                reset,
    input  logic                tick,
    input  logic                left_turn_request,
    input  logic [3:0]          walk_buttons,     // n, s, e, w from low bit up
    output traffic_pkg::phase_t phase
);

    import traffic_pkg::*;

    timer_t     timer;           // ticks left in the current phase
    phase_t     next_phase;
    logic       advance;
    logic [3:0] btn_meta;        // first synchronizer stage
    logic [3:0] btn_sync;        // second stage, safe to use
    logic       walk_set;
    logic       walk_request;    // one pending request shared by all buttons
    logic       walk_entry;

    // the phase ends on the tick that finds one tick left
    assign advance = tick && (timer <= timer_t'(1));

    // transition table
    always_comb
    begin
        case (phase)
            main_green:  next_phase = main_amber;
            main_amber:  next_phase = main_clear;
            main_clear:
            begin
                if (left_turn_request)
                    next_phase = left_turn;     // arrow goes in before the cross road
                else if (walk_request)
                    next_phase = cross_walk;
                else
                    next_phase = cross_green;
            end
            left_turn:   next_phase = walk_request ? cross_walk : cross_green;
            cross_walk:  next_phase = cross_flash;
            cross_flash: next_phase = cross_dont;
            cross_dont:  next_phase = cross_amber; // walk group stands in for the green
            cross_green: next_phase = cross_amber;
            cross_amber: next_phase = cross_clear;
            cross_clear: next_phase = walk_request ? main_walk : main_green;
            main_walk:   next_phase = main_flash;
            main_flash:  next_phase = main_dont;
            main_dont:   next_phase = main_amber;
            default:     next_phase = main_green;  // unused codes recover here
        endcase
    end

    // phase register and duration timer
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            phase <= main_green;
            timer <= phase_duration(main_green);
        end
        else if (advance)
        begin
            phase <= next_phase;
            timer <= phase_duration(next_phase); // full length of the new phase
        end
        else if (tick)
            timer <= timer - 1'b1;
    end

    // buttons are asynchronous to clk
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            btn_meta <= '0;
            btn_sync <= '0;
        end
        else
        begin
            btn_meta <= walk_buttons;
            btn_sync <= btn_meta;
        end
    end

    assign walk_set   = |btn_sync;             // any of the four crossings
    assign walk_entry = advance && ((next_phase == cross_walk) || (next_phase == main_walk));

    // request is served once a walk group begins
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
            walk_request <= 1'b0;
        else if (walk_set)
            walk_request <= 1'b1;              // a press on the entry edge stays pending
        else if (walk_entry)
            walk_request <= 1'b0;
    end

endmodule

/* rtl/signal_decoder.sv */
`timescale 1ns/1ps

module signal_decoder (
    input  traffic_pkg::phase_t phase,
    input  logic                beat,
    output logic [2:0]          northbound_lamps,  // {green, amber, red}
    output logic [2:0]          southbound_lamps,
    output logic [2:0]          eastbound_lamps,
    output logic [2:0]          westbound_lamps,
    output logic                left_turn_arrow,
    output logic [6:0]          northbound_walk,   // active low segments
    output logic [6:0]          southbound_walk,
    output logic [6:0]          eastbound_walk,
    output logic [6:0]          westbound_walk
);

    import traffic_pkg::*;

    logic [2:0] main_lamps;      // shared by north and south
    logic [2:0] cross_lamps;     // shared by east and west
    logic [6:0] main_display;
    logic [6:0] cross_display;

    // one road's lamp set from its own green, amber and walk group phases
    function automatic logic [2:0] road_lamps(logic go, logic slow);
        logic [2:0] l;
        if (go)
            l = 3'b100;
        else if (slow)
            l = 3'b010;
        else
            l = 3'b001;          // red whenever the road is not moving
        return l;
    endfunction

    // walk display of one road, flashing hand follows the beat
    function automatic logic [6:0] walk_display(logic walk, logic flash, logic b);
        logic [6:0] s;
        if (walk)
            s = seg_walk;
        else if (flash)
            s = b ? seg_dont_walk : seg_blank;
        else
            s = seg_dont_walk;
        return s;
    endfunction

    always_comb
    begin
        main_lamps = road_lamps(
            (phase == main_green) || (phase == main_walk) ||
            (phase == main_flash) || (phase == main_dont),
            phase == main_amber);
        cross_lamps = road_lamps(
            (phase == cross_green) || (phase == cross_walk) ||
            (phase == cross_flash) || (phase == cross_dont),
            phase == cross_amber);
        main_display  = walk_display(phase == main_walk, phase == main_flash, beat);
        cross_display = walk_display(phase == cross_walk, phase == cross_flash, beat);
    end

    assign northbound_lamps = main_lamps;
    assign southbound_lamps = main_lamps;
    assign eastbound_lamps  = cross_lamps;
    assign westbound_lamps  = cross_lamps;

    assign left_turn_arrow = (phase == left_turn);  // all roads red meanwhile

    assign northbound_walk = main_display;
    assign southbound_walk = main_display;
    assign eastbound_walk  = cross_display;
    assign westbound_walk  = cross_display;

endmodule

/* rtl/traffic_controller.sv */
`timescale 1ns/1ps

module traffic_controller #(
    parameter int tick_div_slow = 27000000, // 1 tick per second at 27 MHz
    parameter int tick_div_fast = 2700000   // ten times faster for demos
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       overclock,
    input  logic       left_turn_request,
    input  logic       nbnd_walk_req,         // buttons active high
    input  logic       sbnd_walk_req,
    input  logic       ebnd_walk_req,
    input  logic       wbnd_walk_req,
    output logic [2:0] northbound_lamps,      // lamps active high
    output logic [2:0] southbound_lamps,
    output logic [2:0] eastbound_lamps,
    output logic [2:0] westbound_lamps,
    output logic       left_turn_arrow,
    output logic [6:0] northbound_walk,
    output logic [6:0] southbound_walk,
    output logic [6:0] eastbound_walk,
    output logic [6:0] westbound_walk
);

    logic                tick;   // clock enable for the sequencer
    logic                beat;   // flash rate for the walk displays
    traffic_pkg::phase_t phase;

    tick_gen #(
        .tick_div_slow(tick_div_slow),
        .tick_div_fast(tick_div_fast)
    ) tick_gen_i (
        .clk      (clk),
        .reset    (reset),
        .overclock(overclock),
        .tick     (tick),
        .beat     (beat)
    );

    phase_sequencer phase_sequencer_i (
        .clk              (clk),
        .reset            (reset),
        .tick             (tick),
        .left_turn_request(left_turn_request),
        .walk_buttons     ({wbnd_walk_req, ebnd_walk_req, sbnd_walk_req, nbnd_walk_req}),
        .phase            (phase)
    );

    signal_decoder signal_decoder_i (
        .phase           (phase),
        .beat            (beat),
        .northbound_lamps(northbound_lamps),
        .southbound_lamps(southbound_lamps),
        .eastbound_lamps (eastbound_lamps),
        .westbound_lamps (westbound_lamps),
        .left_turn_arrow (left_turn_arrow),
        .northbound_walk (northbound_walk),
        .southbound_walk (southbound_walk),
        .eastbound_walk  (eastbound_walk),
        .westbound_walk  (westbound_walk)
    );

endmodule

/* verification/traffic_controller_tb.sv */
`timescale 1ns/1ps

module traffic_controller_tb;

    import traffic_pkg::*;

    localparam int         div_slow  = 6;      // clk cycles per tick in simulation
    localparam int         div_fast  = 3;
    localparam int         row_count = 5;
    localparam logic [2:0] no_button = 3'd4;

    // phase codes of seq are read from the top nibble down
    typedef struct packed {
        logic        overclock;
        logic        left_turn;
        logic [2:0]  btn_a;     // button index n, s, e, w or no_button
        logic [3:0]  at_a;      // press on the first entry of this phase
        logic [2:0]  btn_b;
        logic [3:0]  at_b;
        logic [4:0]  len;       // number of phases listed
        logic [63:0] seq;
    } row_t;

    logic       clk;
    logic       reset;
    logic       overclock;
    logic       left_turn_request;
    logic [3:0] walk_buttons;      // n, s, e, w from bit 0
    logic [2:0] northbound_lamps;
    logic [2:0] southbound_lamps;
    logic [2:0] eastbound_lamps;
    logic [2:0] westbound_lamps;
    logic       left_turn_arrow;
    logic [6:0] northbound_walk;
    logic [6:0] southbound_walk;
    logic [6:0] eastbound_walk;
    logic [6:0] westbound_walk;

    row_t scenarios [row_count];
    int   error_count = 0;
    int   check_count = 0;
    int   cycle_count = 0;
    int   cycle_limit = 0;

    // reference model state
    int         model_count;
    int         model_div;
    logic       model_tick;
    logic       model_beat;
    phase_t     model_phase;
    logic [5:0] model_timer;
    logic [3:0] model_meta;
    logic [3:0] model_sync;
    logic       model_req;
    phase_t     model_next;
    logic       model_entry;

    traffic_controller #(
        .tick_div_slow(div_slow),
        .tick_div_fast(div_fast)
    ) traffic_controller_i (
        .clk              (clk),
        .reset            (reset),
        .overclock        (overclock),
        .left_turn_request(left_turn_request),
        .nbnd_walk_req    (walk_buttons[0]),
        .sbnd_walk_req    (walk_buttons[1]),
        .ebnd_walk_req    (walk_buttons[2]),
        .wbnd_walk_req    (walk_buttons[3]),
        .northbound_lamps (northbound_lamps),
        .southbound_lamps (southbound_lamps),
        .eastbound_lamps  (eastbound_lamps),
        .westbound_lamps  (westbound_lamps),
        .left_turn_arrow  (left_turn_arrow),
        .northbound_walk  (northbound_walk),
        .southbound_walk  (southbound_walk),
        .eastbound_walk   (eastbound_walk),
        .westbound_walk   (westbound_walk)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;               // 4 ns period
    end

    // phase lengths in ticks
    function automatic logic [5:0] ticks_for(phase_t p);
        case (p)
            main_green, cross_green: return 6'd60;
            main_amber, cross_amber: return 6'd6;
            main_clear, cross_clear: return 6'd2;
            left_turn:               return 6'd20;
            main_walk, cross_walk:   return 6'd10;
            main_flash, cross_flash: return 6'd20;
            default:                 return 6'd30; // don't walk
        endcase
    endfunction

    function automatic phase_t next_phase_for(phase_t p, logic ltr, logic req);
        case (p)
            main_green:  return main_amber;
            main_amber:  return main_clear;
            main_clear:  return ltr ? left_turn : (req ? cross_walk : cross_green);
            left_turn:   return req ? cross_walk : cross_green;
            cross_walk:  return cross_flash;
            cross_flash: return cross_dont;
            cross_green: return cross_amber;
            cross_amber: return cross_clear;
            cross_clear: return req ? main_walk : main_green;
            main_walk:   return main_flash;
            main_flash:  return main_dont;
            main_dont:   return main_amber;
            default:     return cross_amber; // cross_dont
        endcase
    endfunction

    // {green, amber, red} of north and south
    function automatic logic [2:0] main_lamps_for(phase_t p);
        case (p)
            main_green, main_walk, main_flash, main_dont: return 3'b100;
            main_amber:                                   return 3'b010;
            default:                                      return 3'b001;
        endcase
    endfunction

    function automatic logic [2:0] cross_lamps_for(phase_t p);
        case (p)
            cross_green, cross_walk, cross_flash, cross_dont: return 3'b100;
            cross_amber:                                      return 3'b010;
            default:                                          return 3'b001;
        endcase
    endfunction

    function automatic logic [6:0] display_for(phase_t p, logic b, logic cross_road);
        phase_t walk_p;
        phase_t flash_p;
        walk_p  = cross_road ? cross_walk : main_walk;
        flash_p = cross_road ? cross_flash : main_flash;
        if (p == walk_p)
            return seg_walk;
        if (p == flash_p)
            return b ? seg_dont_walk : seg_blank;   // hand blinks with the beat
        return seg_dont_walk;
    endfunction

    // reference model, updated on the same edges as the DUT
    always @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            model_count <= 0;
            model_tick  <= 1'b0;
            model_beat  <= 1'b0;
            model_phase <= main_green;
            model_timer <= 6'd60;
            model_meta  <= 4'b0;
            model_sync  <= 4'b0;
            model_req   <= 1'b0;
        end
        else
        begin
            model_div = overclock ? div_fast : div_slow;
            if (model_count >= model_div - 1)
            begin
                model_count <= 0;
                model_tick  <= 1'b1;
                model_beat  <= ~model_beat;
            end
            else
            begin
                model_count <= model_count + 1;
                model_tick  <= 1'b0;
            end
            model_meta  <= walk_buttons;         // two flop synchronizer
            model_sync  <= model_meta;
            model_entry = 1'b0;
            if (model_tick)
            begin
                if (model_timer <= 6'd1)
                begin
                    model_next = next_phase_for(model_phase, left_turn_request, model_req);
                    model_phase <= model_next;
                    model_timer <= ticks_for(model_next);
                    model_entry = (model_next == cross_walk) || (model_next == main_walk);
                end
                else
                    model_timer <= model_timer - 6'd1;
            end
            if (|model_sync)
                model_req <= 1'b1;               // set beats the clear on entry
            else if (model_entry)
                model_req <= 1'b0;
        end
    end

    // timeout
    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit)
        begin
            $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [6:0] got,
                                 input logic [6:0] exp);
        check_count = check_count + 1;
        if (got !== exp)
        begin
            error_count = error_count + 1;
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_outputs();
        logic [2:0] main_exp;
        logic [2:0] cross_exp;
        logic [6:0] main_disp;
        logic [6:0] cross_disp;
        main_exp   = main_lamps_for(model_phase);
        cross_exp  = cross_lamps_for(model_phase);
        main_disp  = display_for(model_phase, model_beat, 1'b0);
        cross_disp = display_for(model_phase, model_beat, 1'b1);
        compare_value("northbound_lamps", 7'(northbound_lamps), 7'(main_exp));
        compare_value("southbound_lamps", 7'(southbound_lamps), 7'(main_exp));
        compare_value("eastbound_lamps", 7'(eastbound_lamps), 7'(cross_exp));
        compare_value("westbound_lamps", 7'(westbound_lamps), 7'(cross_exp));
        compare_value("left_turn_arrow", 7'(left_turn_arrow), 7'(model_phase == left_turn));
        compare_value("northbound_walk", northbound_walk, main_disp);
        compare_value("southbound_walk", southbound_walk, main_disp);
        compare_value("eastbound_walk", eastbound_walk, cross_disp);
        compare_value("westbound_walk", westbound_walk, cross_disp);
    endtask

    task automatic load_scenarios();
        // plain rounds
        scenarios[0] = '{1'b0, 1'b0, no_button, 4'(main_green), no_button, 4'(main_green),
                         5'd12, 64'h0127_8901_2789_0000};
        // protected left turn every round, westbound walk served after the first arrow
        scenarios[1] = '{1'b0, 1'b1, 3'd3, 4'(main_green), no_button, 4'(main_green),
                         5'd16, 64'h0123_4568_9012_3789};
        // eastbound press during main green, served once
        scenarios[2] = '{1'b0, 1'b0, 3'd2, 4'(main_green), no_button, 4'(main_green),
                         5'd14, 64'h0124_5689_0127_8900};
        // northbound press in cross green, southbound press re-arms in main walk
        scenarios[3] = '{1'b0, 1'b0, 3'd0, 4'(cross_green), 3'd1, 4'(main_walk),
                         5'd16, 64'h0127_89ab_c124_5689};
        // overclock, same phases at 3 cycles per tick
        scenarios[4] = '{1'b1, 1'b0, no_button, 4'(main_green), no_button, 4'(main_green),
                         5'd12, 64'h0127_8901_2789_0000};
    endtask

    function automatic int scenario_cycles(row_t r);
        int ticks;
        int div;
        ticks = 0;
        for (int i = 0; i < int'(r.len); i++)
            ticks = ticks + int'(ticks_for(phase_t'(r.seq[63 - 4*i -: 4])));
        div = r.overclock ? div_fast : div_slow;
        return (ticks + 1) * div + 20;           // plus first tick and reset
    endfunction

    task automatic apply_reset(input row_t r);
        @(posedge clk);
        reset             <= 1'b0;
        overclock         <= r.overclock;
        left_turn_request <= r.left_turn;
        walk_buttons      <= 4'b0;
        repeat (16)
        begin
            @(negedge clk);
            check_outputs();                      // reset state holds throughout
        end
        @(posedge clk);
        reset <= 1'b1;
    endtask

    task automatic run_scenario(input row_t r);
        logic [3:0] prev;
        logic [3:0] cur;
        int         entries;
        int         hold;
        int         press_btn;
        logic       done_a;
        logic       done_b;
        prev      = 4'hf;                         // no phase has this code
        entries   = 0;
        hold      = 0;
        press_btn = 4;
        done_a    = 1'b0;
        done_b    = 1'b0;
        while (entries <= int'(r.len))
        begin
            @(posedge clk);
            if (press_btn < 4)
            begin
                walk_buttons[press_btn] <= 1'b1;
                hold      = 3;                    // held for three cycles
                press_btn = 4;
            end
            else if (hold > 0)
            begin
                hold = hold - 1;
                if (hold == 0)
                    walk_buttons <= 4'b0;
            end
            @(negedge clk);
            check_outputs();
            cur = traffic_controller_i.phase;
            if (cur != prev)
            begin
                if (entries < int'(r.len))
                    compare_value("phase", 7'(cur), 7'(r.seq[63 - 4*entries -: 4]));
                entries = entries + 1;
                prev    = cur;
                if (!done_a && r.btn_a != no_button && cur == r.at_a)
                begin
                    press_btn = int'(r.btn_a);
                    done_a    = 1'b1;
                end
                if (!done_b && r.btn_b != no_button && cur == r.at_b)
                begin
                    press_btn = int'(r.btn_b);
                    done_b    = 1'b1;
                end
            end
        end
    endtask

    initial
    begin
        int total;
        reset             = 1'b0;
        overclock         = 1'b0;
        left_turn_request = 1'b0;
        walk_buttons      = 4'b0;
        load_scenarios();
        total = 0;
        for (int i = 0; i < row_count; i++)
            total = total + scenario_cycles(scenarios[i]);
        cycle_limit = total + total / 10;         // ten percent slack
        for (int i = 0; i < row_count; i++)
        begin
            apply_reset(scenarios[i]);
            run_scenario(scenarios[i]);
        end
        $display("%0d errors in %0d checks", error_count, check_count);
        if (error_count == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

/* vlog.f */
rtl/traffic_pkg.sv
rtl/tick_gen.sv
rtl/phase_sequencer.sv
rtl/signal_decoder.sv
rtl/traffic_controller.sv
verification/traffic_controller_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = traffic_controller_tb
FILELIST = vlog.f
BUILD    = obj_dir
LOG      = sim.log
PASS     = Test OK

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD) $(LOG)
